// ==== files.f ====
hdl/soc_bus_pkg.sv
hdl/bus_op_if.sv
hdl/addr_decoder.sv
hdl/slave_exec.sv
hdl/rsp_collector.sv
hdl/soc_bus_top.sv
tb/tb_clkgen.sv
tb/soc_bus_asserts.sv
tb/soc_bus_tb.sv

// ==== hdl/addr_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module addr_decoder (
    input  logic                             aclk,
    input  logic                             arst_n_i,
    input  logic                             req_valid_i,
    output logic                             req_ready_o,
    input  logic [soc_bus_pkg::ADDR_W-1:0]   req_addr_i,
    input  logic                             req_we_i,
    input  logic [soc_bus_pkg::DATA_W-1:0]   req_wdata_i,
    input  logic [soc_bus_pkg::STRB_W-1:0]   req_wstrb_i,
    input  logic                             rsp_done_i,
    bus_op_if.dec                            op
);
    import soc_bus_pkg::*;

    logic                         busy_q;    // Transaction in flight
    logic                         accept;
    target_e                      target_d;
    logic [ADDR_W-1:SRAM_AW+2]    page;      // 64 KiB page number
    logic [SRAM_AW+1:0]           offset;    // Byte offset inside page

    assign req_ready_o = !busy_q;
    assign accept      = req_valid_i && !busy_q;         // Request handshake
    assign page        = req_addr_i[ADDR_W-1:SRAM_AW+2];
    assign offset      = req_addr_i[SRAM_AW+1:0];

    // Address map, config registers matched on word address
    always_comb begin
        target_d = TGT_NONE;
        if (page == SRAM_BASE[ADDR_W-1:SRAM_AW+2]) begin
            target_d = TGT_SRAM;
        end else if (page == CONF_BASE[ADDR_W-1:SRAM_AW+2]) begin
            case (offset[SRAM_AW+1:2])
                LED_OFF[SRAM_AW+1:2]:     target_d = TGT_LED;
                SWITCH_OFF[SRAM_AW+1:2]:  target_d = TGT_SWITCH;
                SCRATCH_OFF[SRAM_AW+1:2]: target_d = TGT_SCRATCH;
                default:                  target_d = TGT_NONE;   // Hole in config page
            endcase
        end
    end

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q      <= 1'b0;
            op.op_valid <= 1'b0;
        end else begin
            op.op_valid <= accept;                // High for one cycle only
            if (accept) begin
                busy_q <= 1'b1;
            end else if (rsp_done_i) begin
                busy_q <= 1'b0;                   // Ready again after handshake
            end
        end
    end

    // Operation fields, sampled with the request
    always_ff @(posedge aclk) begin
        if (accept) begin
            op.op_target <= target_d;
            op.op_word   <= req_addr_i[SRAM_AW+1:2];
            op.op_we     <= req_we_i;
            op.op_wdata  <= req_wdata_i;
            op.op_wstrb  <= req_wstrb_i;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/bus_op_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface bus_op_if;
    import soc_bus_pkg::*;

    logic                op_valid;   // Single-cycle pulse
    target_e             op_target;  // Decoded slave
    logic [SRAM_AW-1:0]  op_word;    // SRAM word index
    logic                op_we;
    logic [DATA_W-1:0]   op_wdata;
    logic [STRB_W-1:0]   op_wstrb;

    modport dec (
        output op_valid, op_target, op_word, op_we, op_wdata, op_wstrb
    );

    modport exec (
        input  op_valid, op_target, op_word, op_we, op_wdata, op_wstrb
    );

endinterface

`default_nettype wire

// ==== hdl/rsp_collector.sv ====
`timescale 1ns/100ps
`default_nettype none

module rsp_collector (
    input  logic                             aclk,
    input  logic                             arst_n_i,
    input  logic                             res_valid_i,
    input  logic [soc_bus_pkg::DATA_W-1:0]   res_rdata_i,
    input  logic                             res_err_i,
    output logic                             rsp_valid_o,
    input  logic                             rsp_ready_i,
    output logic [soc_bus_pkg::DATA_W-1:0]   rsp_rdata_o,
    output logic                             rsp_err_o,
    output logic                             rsp_done_o
);
    import soc_bus_pkg::*;

    rsp_state_e          state_q;
    logic [DATA_W-1:0]   rdata_q;    // Held response data
    logic                err_q;
    logic                capture;

    assign capture     = (state_q == RSP_IDLE) && res_valid_i;
    assign rsp_valid_o = (state_q == RSP_HOLD);
    assign rsp_done_o  = rsp_valid_o && rsp_ready_i;   // Response handshake
    assign rsp_rdata_o = rdata_q;
    assign rsp_err_o   = err_q;

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= RSP_IDLE;
        end else begin
            case (state_q)
                RSP_IDLE: begin
                    if (res_valid_i) begin
                        state_q <= RSP_HOLD;
                    end
                end
                RSP_HOLD: begin
                    if (rsp_ready_i) begin
                        state_q <= RSP_IDLE;   // Master took it
                    end
                end
                default: state_q <= RSP_IDLE;
            endcase
        end
    end

    // Stable while master applies back-pressure
    always_ff @(posedge aclk) begin
        if (capture) begin
            rdata_q <= res_rdata_i;
            err_q   <= res_err_i;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/slave_exec.sv ====
`timescale 1ns/100ps
`default_nettype none

module slave_exec (
    input  logic                               aclk,
    input  logic                               arst_n_i,
    bus_op_if.exec                             op,
    output logic                               sram_en_o,
    output logic [soc_bus_pkg::STRB_W-1:0]     sram_we_o,
    output logic [soc_bus_pkg::SRAM_AW-1:0]    sram_addr_o,
    output logic [soc_bus_pkg::DATA_W-1:0]     sram_wdata_o,
    input  logic [soc_bus_pkg::DATA_W-1:0]     sram_rdata_i,
    input  logic [soc_bus_pkg::SWITCH_W-1:0]   switch_i,
    output logic [soc_bus_pkg::LED_W-1:0]      led_o,
    output logic                               res_valid_o,
    output logic [soc_bus_pkg::DATA_W-1:0]     res_rdata_o,
    output logic                               res_err_o
);
    import soc_bus_pkg::*;

    // Byte-lane merge of write data into an old register value
    function automatic logic [DATA_W-1:0] merge_bytes(
        input logic [DATA_W-1:0] old_v,
        input logic [DATA_W-1:0] new_v,
        input logic [STRB_W-1:0] strb
    );
        logic [DATA_W-1:0] res;
        res = old_v;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = new_v[b*8 +: 8];
            end
        end
        return res;
    endfunction

    logic                sram_sel;      // SRAM access this cycle
    logic                cfg_wr;
    logic [DATA_W-1:0]   led_wide;      // LED zero-extended to bus width
    logic [DATA_W-1:0]   led_merged;    // LED after byte-lane merge
    logic [LED_W-1:0]    led_q;
    logic [DATA_W-1:0]   scratch_q;
    logic [DATA_W-1:0]   cfg_rdata_q;   // Config read data, zero on writes
    logic                sram_rd_q;     // Result comes from SRAM output
    logic                res_valid_q;
    logic                res_err_q;

    assign sram_sel     = op.op_valid && (op.op_target == TGT_SRAM);
    assign sram_en_o    = sram_sel;
    assign sram_we_o    = (sram_sel && op.op_we) ? op.op_wstrb : '0;   // Strobes on writes only
    assign sram_addr_o  = op.op_word;
    assign sram_wdata_o = op.op_wdata;
    assign cfg_wr       = op.op_valid && op.op_we;
    assign led_wide     = {{(DATA_W-LED_W){1'b0}}, led_q};
    assign led_merged   = merge_bytes(led_wide, op.op_wdata, op.op_wstrb);

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            led_q       <= '0;
            scratch_q   <= '0;
            res_valid_q <= 1'b0;
            res_err_q   <= 1'b0;
            sram_rd_q   <= 1'b0;
        end else begin
            res_valid_q <= op.op_valid;          // Result one cycle after op
            if (op.op_valid) begin
                res_err_q <= (op.op_target == TGT_NONE);
                sram_rd_q <= sram_sel && !op.op_we;
            end
            if (cfg_wr && op.op_target == TGT_LED) begin
                led_q <= led_merged[LED_W-1:0];  // Upper lanes dropped
            end
            if (cfg_wr && op.op_target == TGT_SCRATCH) begin
                scratch_q <= merge_bytes(scratch_q, op.op_wdata, op.op_wstrb);
            end
        end
    end

    // Read data of config targets, switch write falls to zero silently
    always_ff @(posedge aclk) begin
        if (op.op_valid) begin
            if (op.op_we) begin
                cfg_rdata_q <= '0;
            end else begin
                case (op.op_target)
                    TGT_LED:     cfg_rdata_q <= led_wide;
                    TGT_SWITCH:  cfg_rdata_q <= {{(DATA_W-SWITCH_W){1'b0}}, switch_i};
                    TGT_SCRATCH: cfg_rdata_q <= scratch_q;
                    default:     cfg_rdata_q <= '0;   // SRAM and unmapped
                endcase
            end
        end
    end

    assign led_o       = led_q;
    assign res_valid_o = res_valid_q;
    assign res_err_o   = res_err_q;
    assign res_rdata_o = sram_rd_q ? sram_rdata_i : cfg_rdata_q;   // SRAM data arrives now

endmodule

`default_nettype wire

// ==== hdl/soc_bus_pkg.sv ====
`default_nettype none

package soc_bus_pkg;

    localparam int ADDR_W   = 32;   // Byte address bus
    localparam int DATA_W   = 32;   // Data bus
    localparam int STRB_W   = 4;    // One strobe per byte lane
    localparam int SRAM_AW  = 14;   // Word index, 64 KiB window

    // Window bases, both pages are 64 KiB
    localparam logic [ADDR_W-1:0] SRAM_BASE = 32'h0000_0000;
    localparam logic [ADDR_W-1:0] CONF_BASE = 32'hBFAF_0000;

    localparam logic [15:0] LED_OFF     = 16'hF000;  // LED register
    localparam logic [15:0] SWITCH_OFF  = 16'hF020;  // Switch input, read only
    localparam logic [15:0] SCRATCH_OFF = 16'hF030;  // Free scratch word

    localparam int LED_W    = 16;
    localparam int SWITCH_W = 8;

    // Target of a decoded operation, also used as its opcode
    typedef enum logic [2:0] {
        TGT_SRAM,
        TGT_LED,
        TGT_SWITCH,
        TGT_SCRATCH,
        TGT_NONE                      // Unmapped, answered with error
    } target_e;

    typedef enum logic {
        RSP_IDLE,
        RSP_HOLD                      // Response offered to master
    } rsp_state_e;

endpackage

`default_nettype wire

// ==== hdl/soc_bus_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module soc_bus_top (
    input  logic                               aclk,
    input  logic                               arst_n_i,
    // Request channel
    input  logic                               req_valid_i,
    output logic                               req_ready_o,
    input  logic [soc_bus_pkg::ADDR_W-1:0]     req_addr_i,
    input  logic                               req_we_i,
    input  logic [soc_bus_pkg::DATA_W-1:0]     req_wdata_i,
    input  logic [soc_bus_pkg::STRB_W-1:0]     req_wstrb_i,
    // Response channel
    output logic                               rsp_valid_o,
    input  logic                               rsp_ready_i,
    output logic [soc_bus_pkg::DATA_W-1:0]     rsp_rdata_o,
    output logic                               rsp_err_o,
    // External synchronous SRAM
    output logic                               sram_en_o,
    output logic [soc_bus_pkg::STRB_W-1:0]     sram_we_o,
    output logic [soc_bus_pkg::SRAM_AW-1:0]    sram_addr_o,
    output logic [soc_bus_pkg::DATA_W-1:0]     sram_wdata_o,
    input  logic [soc_bus_pkg::DATA_W-1:0]     sram_rdata_i,
    // Board I/O
    output logic [soc_bus_pkg::LED_W-1:0]      led_o,
    input  logic [soc_bus_pkg::SWITCH_W-1:0]   switch_i
);
    import soc_bus_pkg::*;

    logic                res_valid;
    logic [DATA_W-1:0]   res_rdata;
    logic                res_err;
    logic                rsp_done;   // Frees the decoder

    bus_op_if op_bus ();

    addr_decoder u_dec (
        .aclk        (aclk),
        .arst_n_i    (arst_n_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_addr_i  (req_addr_i),
        .req_we_i    (req_we_i),
        .req_wdata_i (req_wdata_i),
        .req_wstrb_i (req_wstrb_i),
        .rsp_done_i  (rsp_done),
        .op          (op_bus)
    );

    slave_exec u_exec (
        .aclk         (aclk),
        .arst_n_i     (arst_n_i),
        .op           (op_bus),
        .sram_en_o    (sram_en_o),
        .sram_we_o    (sram_we_o),
        .sram_addr_o  (sram_addr_o),
        .sram_wdata_o (sram_wdata_o),
        .sram_rdata_i (sram_rdata_i),
        .switch_i     (switch_i),
        .led_o        (led_o),
        .res_valid_o  (res_valid),
        .res_rdata_o  (res_rdata),
        .res_err_o    (res_err)
    );

    rsp_collector u_rsp (
        .aclk        (aclk),
        .arst_n_i    (arst_n_i),
        .res_valid_i (res_valid),
        .res_rdata_i (res_rdata),
        .res_err_i   (res_err),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_rdata_o (rsp_rdata_o),
        .rsp_err_o   (rsp_err_o),
        .rsp_done_o  (rsp_done)
    );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the bus fabric testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module soc_bus_tb \
    -f files.f -o soc_bus_sim

# Pass only when the testbench printed its pass line
./obj_dir/soc_bus_sim | tee /dev/stderr | grep "Everything OK" > /dev/null
echo "Simulation passed"

// ==== tb/soc_bus_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module soc_bus_asserts (
    input logic                               aclk,
    input logic                               arst_n_i,
    input logic                               req_ready_i,
    input logic                               rsp_valid_i,
    input logic                               rsp_ready_i,
    input logic [soc_bus_pkg::DATA_W-1:0]     rsp_rdata_i,
    input logic                               rsp_err_i,
    input logic                               sram_en_i,
    input logic [soc_bus_pkg::STRB_W-1:0]     sram_we_i
);

    // Response frozen while the master stalls
    rsp_hold_a: assert property (@(posedge aclk) disable iff (!arst_n_i)
        rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_rdata_i) && $stable(rsp_err_i))
        else $error("response changed before its handshake");

    // Single transaction in flight
    one_txn_a: assert property (@(posedge aclk) disable iff (!arst_n_i)
        rsp_valid_i |-> !req_ready_i)
        else $error("request accepted while a response is pending");

    sram_we_a: assert property (@(posedge aclk) disable iff (!arst_n_i)
        !sram_en_i |-> sram_we_i == '0)
        else $error("SRAM byte enables active without SRAM enable");

endmodule

bind soc_bus_top soc_bus_asserts u_asserts (
    .aclk        (aclk),
    .arst_n_i    (arst_n_i),
    .req_ready_i (req_ready_o),
    .rsp_valid_i (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_rdata_i (rsp_rdata_o),
    .rsp_err_i   (rsp_err_o),
    .sram_en_i   (sram_en_o),
    .sram_we_i   (sram_we_o)
);

`default_nettype wire

// ==== tb/soc_bus_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module soc_bus_tb;
    import soc_bus_pkg::*;

    localparam int WAIT_LIMIT = 50;   // Cycles per wait loop

    logic                aclk;
    logic                arst_n_i;
    logic                req_valid_i;
    logic                req_ready_o;
    logic                req_we_i;
    logic                rsp_valid_o;
    logic                rsp_ready_i;
    logic                rsp_err_o;
    logic                sram_en_o;
    logic [ADDR_W-1:0]   req_addr_i;
    logic [DATA_W-1:0]   req_wdata_i;
    logic [DATA_W-1:0]   rsp_rdata_o;
    logic [DATA_W-1:0]   sram_wdata_o;
    logic [DATA_W-1:0]   sram_rdata_i;
    logic [STRB_W-1:0]   req_wstrb_i;
    logic [STRB_W-1:0]   sram_we_o;
    logic [SRAM_AW-1:0]  sram_addr_o;
    logic [LED_W-1:0]    led_o;
    logic [SWITCH_W-1:0] switch_i;
    logic [DATA_W-1:0]   sram_mem [2**SRAM_AW];   // External SRAM contents
    logic [DATA_W-1:0]   ref_mem [2**SRAM_AW];    // Model view of the SRAM
    logic [LED_W-1:0]    ref_led;
    logic [DATA_W-1:0]   ref_scratch;
    logic [DATA_W-1:0]   exp_rdata;
    logic                exp_err;
    logic [ADDR_W-1:0]   a;
    logic [ADDR_W-1:0]   b;
    integer              seed;
    integer              check_errs;
    integer              timeout_errs;
    integer              en_count;   // SRAM enable pulses seen
    integer              en_start;

    tb_clkgen u_clk (.clk_o(aclk));
    soc_bus_top UUT (.*);

    // Every word distinct, built from its full word index
    function automatic logic [DATA_W-1:0] fill_word(input logic [SRAM_AW-1:0] w);
        return {~w, 2'b01, w, 2'b10};
    endfunction

    initial begin
        sram_rdata_i <= '0;
        for (int i = 0; i < 2**SRAM_AW; i++) begin
            sram_mem[i] <= fill_word(i);
        end
    end

    // Synchronous SRAM, byte writes, registered read
    always @(posedge aclk) begin
        if (sram_en_o) begin
            for (int k = 0; k < STRB_W; k++) begin
                if (sram_we_o[k]) begin
                    sram_mem[sram_addr_o][k*8 +: 8] <= sram_wdata_o[k*8 +: 8];
                end
            end
            sram_rdata_i <= sram_mem[sram_addr_o];   // Old word on a write
        end
    end

    always @(negedge aclk) begin
        if (sram_en_o) begin
            en_count++;
        end
    end

    function automatic logic [DATA_W-1:0] apply_strobes(input logic [DATA_W-1:0] old_v,
            input logic [DATA_W-1:0] new_v, input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] mask;
        for (int k = 0; k < STRB_W; k++) begin
            mask[k*8 +: 8] = {8{strb[k]}};
        end
        return (old_v & ~mask) | (new_v & mask);
    endfunction

    // Expected response and model update from the address map
    function automatic void predict(input logic [ADDR_W-1:0] addr, input logic we,
            input logic [DATA_W-1:0] wd, input logic [STRB_W-1:0] st);
        logic [DATA_W-1:0] old_v;
        logic [DATA_W-1:0] new_v;
        logic              conf;
        conf    = (addr[31:16] == CONF_BASE[31:16]);
        exp_err = 1'b0;
        if (addr[31:16] == SRAM_BASE[31:16]) begin
            old_v = ref_mem[addr[15:2]];
            ref_mem[addr[15:2]] = we ? apply_strobes(old_v, wd, st) : old_v;
        end else if (conf && addr[15:2] == LED_OFF[15:2]) begin
            old_v   = {{(DATA_W-LED_W){1'b0}}, ref_led};
            new_v   = we ? apply_strobes(old_v, wd, st) : old_v;
            ref_led = new_v[LED_W-1:0];   // Upper lanes dropped
        end else if (conf && addr[15:2] == SCRATCH_OFF[15:2]) begin
            old_v       = ref_scratch;
            ref_scratch = we ? apply_strobes(old_v, wd, st) : old_v;
        end else if (conf && addr[15:2] == SWITCH_OFF[15:2]) begin
            old_v = {{(DATA_W-SWITCH_W){1'b0}}, switch_i};   // Writes ignored
        end else begin
            old_v   = '0;
            exp_err = 1'b1;   // Unmapped
        end
        exp_rdata = we ? '0 : old_v;   // Writes answer with zero
    endfunction

    task automatic compare(input string name, input logic [DATA_W-1:0] got,
            input logic [DATA_W-1:0] exp);
        assert (got === exp) else begin
            check_errs++;
            $display("CHECK FAILED at time %0t: %s is 0x%08h, expected 0x%08h",
                     $time, name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        timeout_errs++;
        $display("Timeout at time %0t: gave up waiting for %s after %0d cycles",
                 $time, what, WAIT_LIMIT);
    endtask

    // One request and response, checks latency and back-pressure
    task automatic transfer(input logic [ADDR_W-1:0] addr, input logic we,
            input logic [DATA_W-1:0] wd, input logic [STRB_W-1:0] st);
        int               n;
        int               stall;
        logic [DATA_W-1:0] rdata;
        logic             err;
        stall       = $unsigned($random(seed)) % 8;
        req_addr_i  = addr;
        req_we_i    = we;
        req_wdata_i = wd;
        req_wstrb_i = st;
        req_valid_i = 1'b1;
        n = 0;
        while (!req_ready_o && n < WAIT_LIMIT) begin
            @(negedge aclk);
            n++;
        end
        @(negedge aclk);                  // Accepting edge lies behind
        req_valid_i = 1'b0;
        if (n == WAIT_LIMIT) begin
            report_timeout("req_ready_o");
            return;
        end
        predict(addr, we, wd, st);
        n = 0;
        while (!rsp_valid_o && n < WAIT_LIMIT) begin
            @(negedge aclk);
            n++;
        end
        if (n == WAIT_LIMIT) begin
            report_timeout("rsp_valid_o");
            return;
        end
        compare("rsp_valid_o delay", n, 2);
        compare("req_ready_o", req_ready_o, 0);
        rdata = rsp_rdata_o;
        err   = rsp_err_o;
        repeat (stall) begin                // Master not ready yet
            @(negedge aclk);
            compare("rsp_valid_o", rsp_valid_o, 1);
            compare("rsp_rdata_o", rsp_rdata_o, rdata);
            compare("rsp_err_o", rsp_err_o, err);
            compare("req_ready_o", req_ready_o, 0);
        end
        rsp_ready_i = 1'b1;
        @(negedge aclk);                  // Handshake edge lies behind
        rsp_ready_i = 1'b0;
        compare("rsp_valid_o", rsp_valid_o, 0);
        compare("req_ready_o", req_ready_o, 1);
        compare("rsp_rdata_o", rdata, exp_rdata);
        compare("rsp_err_o", err, exp_err);
    endtask

    initial begin
        seed         = 90233;
        check_errs   = 0;
        timeout_errs = 0;
        en_count     = 0;
        arst_n_i     = 1'b0;
        req_valid_i  = 1'b0;
        req_addr_i   = '0;
        req_we_i     = 1'b0;
        req_wdata_i  = '0;
        req_wstrb_i  = '0;
        rsp_ready_i  = 1'b0;
        switch_i     = '0;
        ref_led      = '0;
        ref_scratch  = '0;
        for (int i = 0; i < 2**SRAM_AW; i++) begin
            ref_mem[i] = fill_word(i);
        end
        repeat (16) @(negedge aclk);
        arst_n_i = 1'b1;
        @(negedge aclk);
        compare("req_ready_o", req_ready_o, 1);
        compare("rsp_valid_o", rsp_valid_o, 0);
        compare("sram_en_o", sram_en_o, 0);
        compare("sram_we_o", sram_we_o, 0);
        compare("led_o", led_o, 0);

        // SRAM write, read back, then an untouched word
        repeat (40) begin
            a        = SRAM_BASE | ($random(seed) & 32'hFFFF);
            en_start = en_count;
            transfer(a, 1'b1, $random(seed), $random(seed));
            transfer(a, 1'b0, '0, '0);
            transfer(SRAM_BASE | ($random(seed) & 32'hFFFF), 1'b0, '0, '0);
            compare("sram_en_o pulse count", en_count - en_start, 3);
        end

        // Config registers
        repeat (12) begin
            transfer(CONF_BASE | LED_OFF, 1'b1, $random(seed), $random(seed));
            compare("led_o", led_o, ref_led);
            transfer(CONF_BASE | LED_OFF, 1'b0, '0, '0);
            transfer(CONF_BASE | SCRATCH_OFF, 1'b1, $random(seed), $random(seed));
            transfer(CONF_BASE | SCRATCH_OFF, 1'b0, '0, '0);
            switch_i = $random(seed);
            transfer(CONF_BASE | SWITCH_OFF, 1'b0, '0, '0);
            transfer(CONF_BASE | SWITCH_OFF, 1'b1, $random(seed), 4'hF);
            transfer(CONF_BASE | SWITCH_OFF, 1'b0, '0, '0);
            compare("led_o", led_o, ref_led);
        end

        // Outside both windows, and holes in the config page
        repeat (20) begin
            a = $random(seed);
            if (a[31:16] == SRAM_BASE[31:16] || a[31:16] == CONF_BASE[31:16]) begin
                a[31] = ~a[31];
            end
            b = CONF_BASE | ($random(seed) & 32'hFFFF);
            if (b[15:2] == LED_OFF[15:2] || b[15:2] == SWITCH_OFF[15:2]
                    || b[15:2] == SCRATCH_OFF[15:2]) begin
                b[2] = ~b[2];   // Step off a known register
            end
            en_start = en_count;
            transfer(a, 1'b1, $random(seed), 4'hF);
            transfer(a, 1'b0, '0, '0);
            transfer(b, 1'b1, $random(seed), 4'hF);
            transfer(b, 1'b0, '0, '0);
            compare("sram_en_o pulse count", en_count - en_start, 0);
            transfer(CONF_BASE | LED_OFF, 1'b0, '0, '0);
            transfer(CONF_BASE | SCRATCH_OFF, 1'b0, '0, '0);
            transfer(SRAM_BASE | (a & 32'hFFFF), 1'b0, '0, '0);   // Same offset in SRAM
            compare("led_o", led_o, ref_led);
        end

        $display("Failed checks: %0d, timeouts: %0d", check_errs, timeout_errs);
        if (check_errs == 0 && timeout_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/tb_clkgen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
    output logic clk_o
);

    // 40 ns period, starts low
    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;   // Half period
    end

endmodule

`default_nettype wire
